//--- load_pkg.sv
// load pipe package with widths, access size encoding and the shared packet types
`default_nettype none

package load_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////////////////////////

    localparam int xlen      = 32;  // data and address width
    localparam int prf_len   = 6;   // physical register tag
    localparam int rob_len   = 5;
    localparam int rs_size   = 4;   // station entries
    localparam int rs_len    = 2;
    localparam int ram_words = 64;
    localparam int ram_len   = 6;   // word address bits

    // access size as in funct3[1:0]
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    //////////////////////////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////////////////////////

    // load as it leaves dispatch
    typedef struct packed {
        logic               base_ready;
        logic [xlen-1:0]    base;       // value when ready, preg tag in low bits otherwise
        logic [xlen-1:0]    offset;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
        mem_size_e          mem_size;
        logic               load_signed;
    } load_dispatch_t;

    typedef struct packed {
        logic               valid;
        logic [prf_len-1:0] preg;
        logic [xlen-1:0]    value;
    } cdb_t;

    // load leaving the station with its address already formed
    typedef struct packed {
        logic               valid;
        logic [xlen-1:0]    addr;       // byte address
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
        mem_size_e          mem_size;
        logic               load_signed;
    } load_issue_t;

    typedef struct packed {
        logic               valid;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
        logic [xlen-1:0]    value;
    } load_result_t;

    typedef struct packed {
        logic               valid;
        logic [ram_len-1:0] addr;       // word address
        logic [xlen-1:0]    data;
    } store_t;

endpackage

`default_nettype wire

//--- load_station.sv
// load reservation station with dispatch, cdb wakeup, lowest index issue and address add
`default_nettype none

module load_station (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     dispatch_valid,
    input  load_pkg::load_dispatch_t dispatch,
    input  load_pkg::cdb_t           cdb,
    input  logic                     flush,
    output load_pkg::load_issue_t    issue,
    output logic                     full
);

    import load_pkg::*;

    load_dispatch_t     entries [rs_size];
    logic [rs_size-1:0] occupied;
    logic [rs_len:0]    count;       // one bit wider to hold rs_size
    logic [rs_len:0]    count_next;

    logic [rs_len-1:0]  free_idx;
    logic [rs_len-1:0]  pick_idx;
    logic               pick_valid;
    logic               dispatch_hit;    // same cycle broadcast for the incoming load

    //////////////////////////////////////////////////////////////////////
    // entry selection
    //////////////////////////////////////////////////////////////////////

    // lowest free entry takes the dispatch
    always_comb begin
        free_idx = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (!occupied[i]) free_idx = rs_len'(i);
        end
    end

    // lowest ready entry goes to issue
    always_comb begin
        pick_idx   = '0;
        pick_valid = 1'b0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (occupied[i] && entries[i].base_ready) begin
                pick_idx   = rs_len'(i);
                pick_valid = 1'b1;
            end
        end
    end

    assign dispatch_hit = cdb.valid && !dispatch.base_ready &&
                          (dispatch.base[prf_len-1:0] == cdb.preg);

    always_comb begin
        count_next = count;
        if (dispatch_valid) count_next = count_next + (rs_len+1)'(1);
        if (pick_valid)     count_next = count_next - (rs_len+1)'(1);
    end

    //////////////////////////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_size; i++) begin
            if (occupied[i] && !entries[i].base_ready && cdb.valid &&
                entries[i].base[prf_len-1:0] == cdb.preg) begin
                entries[i].base_ready <= 1'b1;
                entries[i].base       <= cdb.value;  // tag replaced by value
            end
        end
        if (dispatch_valid) begin
            entries[free_idx] <= dispatch;
            if (dispatch_hit) begin
                entries[free_idx].base_ready <= 1'b1;
                entries[free_idx].base       <= cdb.value;
            end
        end
    end

    // occupancy and issue register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            occupied    <= '0;
            count       <= '0;
            full        <= 1'b0;
            issue.valid <= 1'b0;
        end else if (flush) begin
            occupied    <= '0;   // mispredict drops everything
            count       <= '0;
            full        <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            if (pick_valid)     occupied[pick_idx] <= 1'b0;
            if (dispatch_valid) occupied[free_idx] <= 1'b1;
            count             <= count_next;
            full              <= (count_next == (rs_len+1)'(rs_size));
            issue.valid       <= pick_valid;
            issue.addr        <= entries[pick_idx].base + entries[pick_idx].offset;
            issue.dest_preg   <= entries[pick_idx].dest_preg;
            issue.rob_idx     <= entries[pick_idx].rob_idx;
            issue.mem_size    <= entries[pick_idx].mem_size;
            issue.load_signed <= entries[pick_idx].load_signed;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // sender must respect full
    a_no_dispatch_full: assert property (@(posedge clock) disable iff (!rst_n)
        dispatch_valid |-> !full);

    // an issue carrying a live entry's rob index needs that entry ready and frees it
    for (genvar g = 0; g < rs_size; g++) begin : g_issue_check
        a_issue_from_ready: assert property (@(posedge clock) disable iff (!rst_n)
            issue.valid && $past(occupied[g]) &&
            issue.rob_idx == $past(entries[g].rob_idx) |->
                $past(entries[g].base_ready) && !occupied[g]);
    end

endmodule

`default_nettype wire

//--- data_ram.sv
// word wide data memory with a store write port and a flushable load read
`default_nettype none

module data_ram (
    input  logic                  clock,
    input  logic                  rst_n,
    input  load_pkg::store_t      store,
    input  load_pkg::load_issue_t issue,
    input  logic                  flush,
    output logic [31:0]           rdata,
    output logic                  rvalid
);

    import load_pkg::*;

    logic [xlen-1:0]    mem [ram_words];
    logic [ram_len-1:0] rd_addr;

    assign rd_addr = issue.addr[ram_len+1:2];  // drop byte offset

    // read sees the old word when a store hits the same edge
    always_ff @(posedge clock) begin
        if (store.valid) mem[store.addr] <= store.data;
        if (issue.valid) rdata <= mem[rd_addr];
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= issue.valid && !flush;
        end
    end

    // address generated in the station must land inside the array
    a_addr_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        issue.valid |-> (issue.addr[xlen-1:ram_len+2] == '0));

endmodule

`default_nettype wire

//--- load_align.sv
// load aligner holding issued tags and extending the addressed byte, half or word
`default_nettype none

module load_align (
    input  logic                   clock,
    input  logic                   rst_n,
    input  load_pkg::load_issue_t  issue,
    input  logic [31:0]            rdata,
    input  logic                   rvalid,
    input  logic                   flush,
    output load_pkg::load_result_t result
);

    import load_pkg::*;

    // tags held while the ram read is in progress
    logic [prf_len-1:0] hold_preg;
    logic [rob_len-1:0] hold_rob;
    logic [1:0]         hold_off;
    mem_size_e          hold_size;
    logic               hold_signed;

    logic [xlen-1:0]    shifted;
    logic [xlen-1:0]    extended;
    logic               misaligned;

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            hold_preg   <= issue.dest_preg;
            hold_rob    <= issue.rob_idx;
            hold_off    <= issue.addr[1:0];
            hold_size   <= issue.mem_size;
            hold_signed <= issue.load_signed;
        end
    end

    assign shifted = rdata >> {hold_off, 3'b000};  // little endian lane select

    always_comb begin
        case (hold_size)
            mem_byte: extended = {{24{hold_signed & shifted[7]}}, shifted[7:0]};
            mem_half: extended = {{16{hold_signed & shifted[15]}}, shifted[15:0]};
            default:  extended = rdata;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid     <= rvalid && !flush;
            result.dest_preg <= hold_preg;
            result.rob_idx   <= hold_rob;
            result.value     <= extended;
        end
    end

    assign misaligned = (issue.mem_size == mem_half && issue.addr[0]) ||
                        (issue.mem_size == mem_word && issue.addr[1:0] != 2'b00);

    // no misaligned support anywhere in the path
    a_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        issue.valid |-> !misaligned);

endmodule

`default_nettype wire

//--- load_pipe_top.sv
// load issue path top joining the reservation station, data ram and aligner
`default_nettype none

module load_pipe_top (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     dispatch_valid,
    input  load_pkg::load_dispatch_t dispatch,
    input  load_pkg::cdb_t           cdb,
    input  load_pkg::store_t         store,
    input  logic                     flush,
    output logic                     full,
    output load_pkg::load_result_t   result
);

    import load_pkg::*;

    load_issue_t issue;   // fans out to ram and aligner
    logic [31:0] rdata;
    logic        rvalid;

    load_station load_station_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .flush          (flush),
        .issue          (issue),
        .full           (full)
    );

    data_ram data_ram_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .store  (store),
        .issue  (issue),
        .flush  (flush),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

    load_align load_align_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .issue  (issue),
        .rdata  (rdata),
        .rvalid (rvalid),
        .flush  (flush),
        .result (result)
    );

endmodule

`default_nettype wire

//--- tb_load_checker.sv
// result checker matching finished loads to their expected values by rob index
`default_nettype none

module tb_load_checker (
    input  logic                            clock,
    input  logic                            rst_n,
    input  load_pkg::load_result_t          result,
    input  logic                            expect_valid,
    input  logic [load_pkg::rob_len-1:0]    expect_rob,
    input  logic [load_pkg::prf_len-1:0]    expect_preg,
    input  logic [load_pkg::xlen-1:0]       expect_value,
    input  logic [2**load_pkg::rob_len-1:0] kill_mask,
    input  logic                            end_check,
    output int                              pass_count,
    output int                              fail_count,
    output int                              pending_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import load_pkg::*;

    logic               pending   [2**rob_len];  // load dispatched, result not seen yet
    logic [xlen-1:0]    exp_value [2**rob_len];
    logic [prf_len-1:0] exp_preg  [2**rob_len];

    task automatic check_result();
        if (!pending[result.rob_idx]) begin
            $display("error at %0t: rob %0d returned a result but no such load is outstanding",
                     $time, result.rob_idx);
            fail_count++;
        end else if (result.value !== exp_value[result.rob_idx] ||
                     result.dest_preg !== exp_preg[result.rob_idx]) begin
            $display("CHECK FAILED at %0t: rob %0d got preg %0d value %h, expected preg %0d value %h",
                     $time, result.rob_idx, result.dest_preg, result.value,
                     exp_preg[result.rob_idx], exp_value[result.rob_idx]);
            fail_count++;
            pending[result.rob_idx] = 1'b0;
        end else begin
            $display("load rob %0d ok, preg %0d value %h",
                     result.rob_idx, result.dest_preg, result.value);
            pass_count++;
            pending[result.rob_idx] = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bookkeeping, one update per clock
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (!rst_n) begin
            pass_count = 0;
            fail_count = 0;
            for (int i = 0; i < 2**rob_len; i++) pending[i] = 1'b0;
        end else begin
            if (result.valid) check_result();
            // flushed loads must never show up again
            for (int i = 0; i < 2**rob_len; i++) begin
                if (kill_mask[i]) pending[i] = 1'b0;
            end
            if (expect_valid) begin
                pending[expect_rob]   = 1'b1;
                exp_value[expect_rob] = expect_value;
                exp_preg[expect_rob]  = expect_preg;
            end
            if (end_check) begin
                for (int i = 0; i < 2**rob_len; i++) begin
                    if (pending[i]) begin
                        $display("error: load rob %0d never returned a result", i);
                        fail_count++;
                    end
                end
            end
        end
    end

    always_comb begin
        pending_count = 0;
        for (int i = 0; i < 2**rob_len; i++) begin
            if (pending[i]) pending_count = pending_count + 1;
        end
    end

endmodule

`default_nettype wire

//--- tb_load_pipe.sv
// testbench top for the load issue path, driven by a command file with expected values
`default_nettype none

module tb_load_pipe;

    timeunit 1ns;
    timeprecision 1ps;

    import load_pkg::*;

    logic                  clock;
    logic                  rst_n;
    logic                  dispatch_valid;
    load_dispatch_t        dispatch;
    cdb_t                  cdb;
    store_t                store;
    logic                  flush;
    logic                  full;
    load_result_t          result;

    // expectations and cancellations toward the checker
    logic                  expect_valid;
    logic [rob_len-1:0]    expect_rob;
    logic [prf_len-1:0]    expect_preg;
    logic [xlen-1:0]       expect_value;
    logic [2**rob_len-1:0] kill_mask;    // one bit per rob index
    logic                  end_check;
    int                    pass_count;
    int                    fail_count;
    int                    pending_count;

    int fd;
    int timeout_cycles;
    int top_passes;
    int top_errors;

    always #50 clock = ~clock;

    load_pipe_top load_pipe_top_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .store          (store),
        .flush          (flush),
        .full           (full),
        .result         (result)
    );

    tb_load_checker result_checker (
        .clock         (clock),
        .rst_n         (rst_n),
        .result        (result),
        .expect_valid  (expect_valid),
        .expect_rob    (expect_rob),
        .expect_preg   (expect_preg),
        .expect_value  (expect_value),
        .kill_mask     (kill_mask),
        .end_check     (end_check),
        .pass_count    (pass_count),
        .fail_count    (fail_count),
        .pending_count (pending_count)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic release_strobes();
        dispatch_valid = 1'b0;
        cdb.valid      = 1'b0;
        store.valid    = 1'b0;
        flush          = 1'b0;
        expect_valid   = 1'b0;
        kill_mask      = '0;
    endtask

    // quiet idles expect no load to complete
    task automatic idle(input int cycles, input int quiet);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            if (i == 0) release_strobes();
            if (quiet != 0 && result.valid) begin
                $display("error at %0t: rob %0d completed before its base was broadcast",
                         $time, result.rob_idx);
                top_errors++;
            end
        end
    endtask

    task automatic read_dispatch();
        logic [31:0] ready;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] preg;
        logic [31:0] rob;
        logic [31:0] size;
        logic [31:0] sgn;
        logic [31:0] value;
        int          code;
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                       ready, base, offset, preg, rob, size, sgn, value);
        if (code != 8) begin
            $display("error: a D line in the command file is incomplete");
            top_errors++;
        end
        dispatch_valid       = 1'b1;
        dispatch.base_ready  = ready[0];
        dispatch.base        = base;
        dispatch.offset      = offset;
        dispatch.dest_preg   = preg[prf_len-1:0];
        dispatch.rob_idx     = rob[rob_len-1:0];
        dispatch.mem_size    = mem_size_e'(size[1:0]);
        dispatch.load_signed = sgn[0];
        expect_valid         = 1'b1;      // checker learns the expected value here
        expect_rob           = rob[rob_len-1:0];
        expect_preg          = preg[prf_len-1:0];
        expect_value         = value;
    endtask

    task automatic check_full();
        if (full !== 1'b1) begin
            $display("CHECK FAILED at %0t: full is low with every entry taken", $time);
            top_errors++;
        end else begin
            $display("full check ok at %0t", $time);
            top_passes++;
        end
    endtask

    task automatic run_commands();
        string       cmd;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        int          code;
        int          n;
        int          m;
        bit          done;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                $display("error: the command file ended without an E line");
                top_errors++;
                done = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);     // comment line
            end else if (cmd == "S") begin
                code        = $fscanf(fd, "%h %h", a, b);
                store.valid = 1'b1;
                store.addr  = a[ram_len-1:0];
                store.data  = b;
            end else if (cmd == "D") begin
                read_dispatch();
            end else if (cmd == "C") begin
                code      = $fscanf(fd, "%h %h", a, b);
                cdb.valid = 1'b1;
                cdb.preg  = a[prf_len-1:0];
                cdb.value = b;
            end else if (cmd == "I") begin
                code = $fscanf(fd, "%d %d", n, m);
                idle(n, m);
            end else if (cmd == "F") begin
                code  = $fscanf(fd, "%d", n);
                flush = 1'b1;
                for (int k = 0; k < n; k++) begin
                    code = $fscanf(fd, "%h", a);
                    kill_mask[a[rob_len-1:0]] = 1'b1;
                end
            end else if (cmd == "Q") begin
                check_full();
            end else if (cmd == "E") begin
                done = 1'b1;
            end else begin
                $display("error: unknown command %s in the command file", cmd);
                top_errors++;
                done = 1'b1;
            end
        end
    endtask

    // wait for outstanding loads, then let the checker list the missing ones
    task automatic drain();
        int waited;
        waited = 0;
        while (pending_count != 0 && waited < 40) begin
            @(negedge clock);
            waited++;
        end
        end_check = 1'b1;
        @(negedge clock);
        end_check = 1'b0;
        @(negedge clock);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        string line;
        int    lines;
        int    code;
        clock          = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb            = '0;
        store          = '0;
        flush          = 1'b0;
        expect_valid   = 1'b0;
        expect_rob     = '0;
        expect_preg    = '0;
        expect_value   = '0;
        kill_mask      = '0;
        end_check      = 1'b0;
        top_passes     = 0;
        top_errors     = 0;
        lines          = 0;
        fd = $fopen("load_tests.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open load_tests.txt");
            $display("Verification failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) lines++;
            end
            $fclose(fd);
            fd = $fopen("load_tests.txt", "r");
            timeout_cycles = lines * 20;
            repeat (5) @(posedge clock);
            @(negedge clock);
            rst_n = 1'b1;
            run_commands();
            drain();
            $fclose(fd);
            $display("tests done: %0d passed, %0d failed",
                     pass_count + top_passes, fail_count + top_errors);
            if (fail_count + top_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- load_tests.txt
# S waddr data | D ready base offset dest rob size(0 b,1 h,2 w) signed expected
# C preg value | I cycles quiet | F count robs | Q full high | E end
S 04 8899aabb I 1 0
S 05 f00d8123 I 1 0
S 10 12345678 I 1 0
D 1 00000010 00000001 01 00 0 1 ffffffaa I 1 0
D 1 00000010 00000003 02 01 0 0 00000088 I 1 0
D 1 00000014 00000000 03 02 1 1 ffff8123 I 1 0
D 1 00000014 00000002 04 03 1 0 0000f00d I 1 0
D 1 00000000 00000040 05 04 2 0 12345678 I 8 0
D 0 00000021 00000010 06 05 2 0 8899aabb I 1 0
C 22 00000000 I 6 1
C 21 00000000 I 6 0
D 0 00000023 00000010 07 06 0 1 ffffffbb C 23 00000000 I 6 0
D 0 00000030 00000010 08 07 2 0 8899aabb I 1 0
D 0 00000031 00000014 09 08 2 0 f00d8123 I 1 0
D 0 00000032 00000012 0a 09 1 1 ffff8899 I 1 0
D 0 00000033 00000000 0b 0a 0 0 000000f0 I 1 0 Q
C 33 00000017 I 1 0
C 32 00000000 I 1 0
C 31 00000000 I 1 0
C 30 00000000 I 8 0
D 0 00000034 00000010 0c 0b 2 0 8899aabb I 1 0
D 1 00000000 00000014 0d 0c 2 0 f00d8123 I 2 0
F 2 0b 0c I 1 0
C 34 00000000 I 5 1
D 1 00000000 00000040 0e 0d 2 0 12345678 I 6 0
S 04 cafe0001 I 3 0
D 1 00000010 00000000 0f 0e 2 0 cafe0001 I 1 0
D 1 0000000f 00000004 10 0f 0 1 ffffffca I 6 0
E

//--- project.f
load_pkg.sv
load_station.sv
data_ram.sv
load_align.sv
load_pipe_top.sv
tb_load_checker.sv
tb_load_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the load pipe testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_load_pipe -o tb_load_pipe

./obj_dir/tb_load_pipe | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
